// File: cpu_checker.sv
// ============================================================
// Testbench checker for mini_cpu. Runs an instruction-set
// model over the program image, then compares every port
// write and the halt behavior against it.
// ============================================================

`timescale 1ns/1ps

module cpu_checker
    import cpu_pkg::*;
#(
    parameter logic [31:0] seed = 32'hfd8d
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] out_pins,
    input  logic       out_strobe,
    input  logic       halted,
    output int         model_steps,
    output int         pass_count,
    output int         fail_count,
    output logic       done
);

    localparam int max_steps     = 200;
    localparam int max_writes    = 64;
    localparam int n_tests       = 5;
    localparam int settle_cycles = 20;

    logic [7:0] prog [rom_depth];
    logic [7:0] exp_data [max_writes];
    int         exp_test [max_writes];
    int         exp_count;
    int         test_exp [n_tests];
    int         test_seen [n_tests];
    int         test_err [n_tests];
    int         wr_idx;
    int         post_halt_writes;
    int         halt_cycles;
    int         halt_drops;
    logic       model_halted;

    function automatic string test_name(int t);
        case (t)
            0:       return "logic_move";
            1:       return "arith_carry";
            2:       return "input_loop";
            3:       return "branch_not_taken";
            default: return "halt";
        endcase
    endfunction

    // Program region of each write address in the image
    function automatic int test_of_addr(logic [7:0] addr);
        if (addr < 8'h09) return 0;
        if (addr < 8'h1b) return 1;
        if (addr < 8'h27) return 2;
        return 3;
    endfunction

    // Input pin value in force after k port writes
    function automatic logic [7:0] input_after_writes(int k);
        logic [31:0] x;
        x = seed;
        for (int i = 0; i <= k; i++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x[7:0];
    endfunction

    function automatic int signed_val(logic [7:0] x);
        return x[7] ? int'(x) - 256 : int'(x);
    endfunction

    // ========================================================
    // Reference model that fills the expected write list
    // ========================================================
    function automatic int run_model();
        logic [7:0] r [4];
        flags_t     f;
        logic [7:0] pc;
        logic [7:0] at;
        logic [7:0] ins;
        logic [7:0] imm;
        logic [7:0] res;
        opcode_e    op;
        int         a;
        int         b;
        int         sv;
        int         steps;
        logic       alu;
        for (int i = 0; i < 4; i++) begin
            r[i] = 8'h00;
        end
        f            = '0;
        pc           = 8'h00;
        steps        = 0;
        exp_count    = 0;
        model_halted = 1'b0;
        while (!model_halted && steps < max_steps) begin
            at  = pc;
            ins = prog[at];
            imm = prog[at + 8'd1];
            if ($isunknown(ins)) begin
                $display("Reference model reached unprogrammed address 0x%02h", at);
                return steps;
            end
            op    = opcode_e'(ins[7:4]);
            a     = ins[3:2];
            b     = ins[1:0];
            steps = steps + 1;
            alu   = 1'b0;
            res   = r[a];
            // LDM and the jumps carry a second byte
            if (op inside {op_ldm, op_jz, op_jc, op_jmp}) begin
                pc = at + 8'd2;
            end else begin
                pc = at + 8'd1;
            end
            case (op)
                op_nop: ;
                op_mov: r[a] = r[b];
                op_add: begin
                    res = r[a] + r[b];
                    sv  = signed_val(r[a]) + signed_val(r[b]);
                    f.c = (int'(r[a]) + int'(r[b])) > 255;
                    f.v = (sv > 127) || (sv < -128);
                    alu = 1'b1;
                end
                op_sub: begin
                    res = r[a] - r[b];
                    sv  = signed_val(r[a]) - signed_val(r[b]);
                    f.c = r[a] < r[b];
                    f.v = (sv > 127) || (sv < -128);
                    alu = 1'b1;
                end
                op_and: begin
                    res = r[a] & r[b];
                    f.c = 1'b0;
                    f.v = 1'b0;
                    alu = 1'b1;
                end
                op_or: begin
                    res = r[a] | r[b];
                    f.c = 1'b0;
                    f.v = 1'b0;
                    alu = 1'b1;
                end
                op_inc: begin
                    res = r[a] + 8'd1;
                    f.c = (r[a] == 8'hff);
                    f.v = (r[a] == 8'h7f);
                    alu = 1'b1;
                end
                op_dec: begin
                    res = r[a] - 8'd1;
                    f.c = (r[a] == 8'h00);
                    f.v = (r[a] == 8'h80);
                    alu = 1'b1;
                end
                op_in:  r[a] = input_after_writes(exp_count);
                op_ldm: r[a] = imm;
                op_out: begin
                    if (exp_count < max_writes) begin
                        exp_data[exp_count] = r[a];
                        exp_test[exp_count] = test_of_addr(at);
                        exp_count = exp_count + 1;
                    end
                end
                op_jz:  pc = f.z ? imm : pc;
                op_jc:  pc = f.c ? imm : pc;
                op_jmp: pc = imm;
                op_hlt: model_halted = 1'b1;
                default: begin
                    $display("Reference model met undefined opcode 0x%h at 0x%02h",
                             ins[7:4], at);
                    return steps;
                end
            endcase
            if (alu) begin
                r[a] = res;
                f.z  = (res == 8'h00);
                f.n  = res[7];
            end
        end
        return steps;
    endfunction

    task automatic finish_test(int t);
        if (test_err[t] == 0) begin
            pass_count = pass_count + 1;
            $display("test %s: passed", test_name(t));
        end else begin
            fail_count = fail_count + 1;
            $display("test %s: failed with %0d errors", test_name(t), test_err[t]);
        end
    endtask

    task automatic check_write(int idx, logic [7:0] actual);
        int t;
        t = exp_test[idx];
        test_seen[t] = test_seen[t] + 1;
        if (actual !== exp_data[idx]) begin
            $display("Error: test %s write %0d: expected 0x%02h, actual 0x%02h",
                     test_name(t), test_seen[t], exp_data[idx], actual);
            test_err[t] = test_err[t] + 1;
        end
        if (test_seen[t] == test_exp[t]) begin
            finish_test(t);
        end
    endtask

    initial begin
        done             = 1'b0;
        pass_count       = 0;
        fail_count       = 0;
        wr_idx           = 0;
        post_halt_writes = 0;
        for (int t = 0; t < n_tests; t++) begin
            test_exp[t]  = 0;
            test_seen[t] = 0;
            test_err[t]  = 0;
        end
        $readmemh(prog_file, prog);
        model_steps = run_model();
        if (!model_halted) begin
            $display("Reference model did not reach HLT within %0d instructions", max_steps);
            fail_count = fail_count + 1;
        end
        for (int i = 0; i < exp_count; i++) begin
            test_exp[exp_test[i]] = test_exp[exp_test[i]] + 1;
        end
    end

    // ========================================================
    // Port write monitor
    // ========================================================
    always @(negedge clk) begin
        if (rst_n === 1'b0 && out_strobe === 1'b1) begin
            if (halted === 1'b1) begin
                $display("Port write of 0x%02h after the CPU halted", out_pins);
                post_halt_writes = post_halt_writes + 1;
            end
            if (wr_idx < exp_count) begin
                check_write(wr_idx, out_pins);
            end else begin
                $display("Unexpected port write of 0x%02h, only %0d writes expected",
                         out_pins, exp_count);
            end
            wr_idx = wr_idx + 1;
        end
    end

    // Halt timing and quiet period checks with closing of open tests
    initial begin
        halt_cycles = 0;
        halt_drops  = 0;
        @(negedge rst_n);
        while (halted !== 1'b1) begin
            @(negedge clk);
            halt_cycles = halt_cycles + 1;
        end
        // Three cycles for every instruction up to and including HLT
        if (model_halted && halt_cycles != 3 * model_steps) begin
            $display("Error: test halt: expected halted after %0d cycles, actual %0d",
                     3 * model_steps, halt_cycles);
            test_err[4] = test_err[4] + 1;
        end
        for (int i = 0; i < settle_cycles; i++) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                halt_drops = halt_drops + 1;
            end
        end
        for (int t = 0; t < n_tests - 1; t++) begin
            if (test_seen[t] < test_exp[t]) begin
                $display("test %s saw only %0d of %0d expected writes",
                         test_name(t), test_seen[t], test_exp[t]);
                test_err[t] = test_err[t] + 1;
                finish_test(t);
            end
        end
        if (wr_idx != exp_count) begin
            $display("Error: test halt: expected %0d writes, actual %0d", exp_count, wr_idx);
            test_err[4] = test_err[4] + 1;
        end
        if (halt_drops != 0) begin
            $display("halted went low again in %0d cycles after the halt", halt_drops);
            test_err[4] = test_err[4] + 1;
        end
        if (post_halt_writes != 0) begin
            test_err[4] = test_err[4] + 1;
        end
        finish_test(4);
        done = 1'b1;
    end

endmodule

// File: cpu_ctrl_fsm.sv
// ============================================================
// Controller: sequences fetch, decode and execute, holds the
// instruction register and decodes the datapath enables.
// Each instruction spends exactly one cycle in every state.
// ============================================================

`timescale 1ns/1ps

module cpu_ctrl_fsm
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] rom_data,
    output logic              pc_inc,
    output exec_ctrl_t        ctrl,
    output logic              halted
);

    state_e            state;
    state_e            state_next;
    logic [data_w-1:0] ir;
    opcode_e           ir_op;
    opcode_e           rom_op;

    assign ir_op  = opcode_e'(ir[7:4]);
    assign rom_op = opcode_e'(rom_data[7:4]);

    // ========================================================
    // State sequencing
    // ========================================================
    always_comb begin
        state_next = state;
        case (state)
            s_fetch:  state_next = s_decode;
            s_decode: state_next = s_exec;
            s_exec:   state_next = (ir_op == op_hlt) ? s_halt : s_fetch;
            s_halt:   state_next = s_halt;
            default:  state_next = s_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state <= s_fetch;
            ir    <= '0;
        end else begin
            state <= state_next;
            // The opcode byte is on the ROM output during decode
            if (state == s_decode) begin
                ir <= rom_data;
            end
        end
    end

    // Step past the opcode, and past the operand for two-byte forms
    assign pc_inc = (state == s_fetch) ||
                    ((state == s_decode) && is_two_byte(rom_op));

    // ========================================================
    // Decode
    // ========================================================
    always_comb begin
        ctrl.opcode   = ir_op;
        ctrl.ra       = ir[3:2];
        ctrl.rb       = ir[1:0];
        ctrl.exec     = (state == s_exec);
        ctrl.two_byte = is_two_byte(ir_op);

        ctrl.reg_write = 1'b0;
        ctrl.set_flags = 1'b0;
        case (ir_op)
            op_mov, op_in, op_ldm: begin
                ctrl.reg_write = 1'b1;
            end
            op_add, op_sub, op_and, op_or, op_inc, op_dec: begin
                ctrl.reg_write = 1'b1;
                ctrl.set_flags = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
                ctrl.set_flags = 1'b0;
            end
        endcase
    end

    // High from the first cycle in s_halt until reset
    assign halted = (state == s_halt);

endmodule

// File: cpu_pkg.sv
// ============================================================
// Shared definitions for the mini_cpu core: widths, opcodes,
// controller states and the structs passed between blocks.
// Compile this package before any other design file.
// ============================================================

package cpu_pkg;

    // ========================================================
    // Widths and sizes
    // ========================================================
    localparam int data_w     = 8;
    localparam int reg_addr_w = 2;
    localparam int flag_w     = 4;
    localparam int rom_depth  = 256;

    // Program image shared by the ROM and the reference model
    localparam string prog_file = "prog.mem";

    // ========================================================
    // Instruction set and controller states
    // ========================================================
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,
        op_add = 4'd2,
        op_sub = 4'd3,
        op_and = 4'd4,
        op_or  = 4'd5,
        op_inc = 4'd6,
        op_dec = 4'd7,
        op_in  = 4'd8,
        op_out = 4'd9,
        op_ldm = 4'd10,
        op_jz  = 4'd11,
        op_jc  = 4'd12,
        op_jmp = 4'd13,
        op_hlt = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        s_fetch  = 2'd0,
        s_decode = 2'd1,
        s_exec   = 2'd2,
        s_halt   = 2'd3
    } state_e;

    // Condition register with Z in the top bit
    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    // Decoded instruction as seen by the datapath
    typedef struct packed {
        opcode_e               opcode;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
        logic                  exec;
        logic                  two_byte;
        logic                  reg_write;
        logic                  set_flags;
    } exec_ctrl_t;

    // Instructions whose second byte is an immediate or a target
    function automatic logic is_two_byte(opcode_e op);
        return op inside {op_ldm, op_jz, op_jc, op_jmp};
    endfunction

endpackage

// File: exec_unit.sv
// ============================================================
// Execution unit: ALU with flag generation, the condition
// register, the jump decision and the output port.
// State here changes only at the close of an execute cycle.
// ============================================================

`timescale 1ns/1ps

module exec_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  exec_ctrl_t        ctrl,
    input  logic [data_w-1:0] ra_data,
    input  logic [data_w-1:0] rb_data,
    input  logic [data_w-1:0] operand,
    input  logic [data_w-1:0] in_pins,
    output logic [data_w-1:0] wr_data,
    output logic              branch_taken,
    output logic [data_w-1:0] out_pins,
    output logic              out_strobe
);

    flags_t          flags;
    flags_t          flags_new;
    logic [data_w:0] wide;

    // ========================================================
    // ALU
    // ========================================================
    always_comb begin
        wide        = {1'b0, ra_data};
        flags_new   = flags;
        flags_new.c = 1'b0;
        flags_new.v = 1'b0;
        case (ctrl.opcode)
            op_mov: wide = {1'b0, rb_data};
            op_add: begin
                wide        = {1'b0, ra_data} + {1'b0, rb_data};
                flags_new.c = wide[data_w];
                flags_new.v = (ra_data[7] == rb_data[7]) && (wide[7] != ra_data[7]);
            end
            op_sub: begin
                // Bit 8 of the difference is the borrow
                wide        = {1'b0, ra_data} - {1'b0, rb_data};
                flags_new.c = wide[data_w];
                flags_new.v = (ra_data[7] != rb_data[7]) && (wide[7] != ra_data[7]);
            end
            op_and: wide = {1'b0, ra_data & rb_data};
            op_or:  wide = {1'b0, ra_data | rb_data};
            op_inc: begin
                wide        = {1'b0, ra_data} + 1'b1;
                flags_new.c = wide[data_w];
                flags_new.v = !ra_data[7] && wide[7];
            end
            op_dec: begin
                wide        = {1'b0, ra_data} - 1'b1;
                flags_new.c = wide[data_w];
                flags_new.v = ra_data[7] && !wide[7];
            end
            op_in:   wide = {1'b0, in_pins};
            op_ldm:  wide = {1'b0, operand};
            default: wide = {1'b0, ra_data};
        endcase
        flags_new.z = (wide[data_w-1:0] == '0);
        flags_new.n = wide[7];
    end

    assign wr_data = wide[data_w-1:0];

    // Condition register that only ALU operations touch
    always_ff @(posedge clk) begin
        if (rst_n) begin
            flags <= '0;
        end else if (ctrl.exec && ctrl.set_flags) begin
            flags <= flags_new;
        end
    end

    // Jumps test the flags left by an earlier instruction
    always_comb begin
        branch_taken = 1'b0;
        if (ctrl.exec && ctrl.two_byte) begin
            case (ctrl.opcode)
                op_jmp:  branch_taken = 1'b1;
                op_jz:   branch_taken = flags.z;
                op_jc:   branch_taken = flags.c;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    // ========================================================
    // Output port
    // ========================================================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            out_pins   <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= ctrl.exec && (ctrl.opcode == op_out);
            if (ctrl.exec && (ctrl.opcode == op_out)) begin
                out_pins <= ra_data;
            end
        end
    end

endmodule

// File: instr_rom.sv
// ============================================================
// Program ROM with one cycle of read latency.
// Contents come from the hex program image at time zero.
// ============================================================

`timescale 1ns/1ps

module instr_rom
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic [data_w-1:0] addr,
    output logic [data_w-1:0] data
);

    logic [data_w-1:0] mem [rom_depth];

    initial begin
        $readmemh(prog_file, mem);
    end

    // Registered read so the word appears the cycle after addr
    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

// File: mini_cpu.f
cpu_pkg.sv
instr_rom.sv
pc_counter.sv
cpu_ctrl_fsm.sv
reg_file.sv
exec_unit.sv
mini_cpu.sv
cpu_checker.sv
tb_mini_cpu.sv

// File: mini_cpu.sv
// ============================================================
// Top level of the 8-bit multi-cycle CPU. Connects the ROM,
// program counter, controller, registers and execution unit.
// ============================================================

`timescale 1ns/1ps

module mini_cpu
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] in_pins,
    output logic [data_w-1:0] out_pins,
    output logic              out_strobe,
    output logic              halted
);

    logic [data_w-1:0] pc;
    logic [data_w-1:0] rom_data;
    logic              pc_inc;
    exec_ctrl_t        ctrl;
    logic [data_w-1:0] ra_data;
    logic [data_w-1:0] rb_data;
    logic [data_w-1:0] wr_data;
    logic              branch_taken;

    instr_rom i_rom (
        .clk  (clk),
        .addr (pc),
        .data (rom_data)
    );

    // The second instruction byte doubles as the jump target
    pc_counter i_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .inc    (pc_inc),
        .load   (branch_taken),
        .target (rom_data),
        .pc     (pc)
    );

    cpu_ctrl_fsm i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rom_data (rom_data),
        .pc_inc   (pc_inc),
        .ctrl     (ctrl),
        .halted   (halted)
    );

    reg_file i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (ctrl.ra),
        .rb      (ctrl.rb),
        .we      (ctrl.reg_write && ctrl.exec),
        .wr_data (wr_data),
        .ra_data (ra_data),
        .rb_data (rb_data)
    );

    exec_unit i_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .ra_data      (ra_data),
        .rb_data      (rb_data),
        .operand      (rom_data),
        .in_pins      (in_pins),
        .wr_data      (wr_data),
        .branch_taken (branch_taken),
        .out_pins     (out_pins),
        .out_strobe   (out_strobe)
    );

endmodule

// File: pc_counter.sv
// ============================================================
// Program counter. Steps by one on inc and takes the jump
// target on load; load wins when both are high.
// ============================================================

`timescale 1ns/1ps

module pc_counter
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inc,
    input  logic              load,
    input  logic [data_w-1:0] target,
    output logic [data_w-1:0] pc
);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            // Execution starts at address 0
            pc <= '0;
        end else if (load) begin
            pc <= target;
        end else if (inc) begin
            // Wraps from 255 back to 0
            pc <= pc + 1'b1;
        end
    end

endmodule

// File: prog.mem
// Program image: hex bytes from address 0, one opcode byte then an optional operand byte
// Opcode in bits 7:4, register A in bits 3:2, register B in bits 1:0
A0 CA A4 5F 18 49 98 51 90        // 00 logic and move, two writes
A0 F0 A4 20 21 C0 14              // 09 ADD with carry out, then JC
AC EE 9C F0                       // 10 reached only if JC falls through
AC A5 9C 31 90 60 90              // 14 jump marker, SUB and INC results
A4 03 A8 00                       // 1B loop counter and accumulator
80 28 98 74 B0 27 D0 1F           // 1F input loop
AC 01 6C B0 30 A0 3C 90 F0        // 27 JZ falls through, marker, HLT
A0 C3 90 F0                       // 30 reached only on a taken JZ

// File: reg_file.sv
// ============================================================
// Four general registers, two combinational read ports and
// one write port addressed by the ra field.
// ============================================================

`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    input  logic                  we,
    input  logic [data_w-1:0]     wr_data,
    output logic [data_w-1:0]     ra_data,
    output logic [data_w-1:0]     rb_data
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[ra] <= wr_data;
        end
    end

    assign ra_data = regs[ra];
    assign rb_data = regs[rb];

endmodule

// File: tb_mini_cpu.sv
// ============================================================
// Testbench top for mini_cpu. Makes clock and reset, drives
// the input pins from an xorshift sequence, bounds the run
// and prints the final result. Checking is in cpu_checker.
// ============================================================

`timescale 1ns/1ps

module tb_mini_cpu;

    localparam logic [31:0] rng_seed     = 32'hfd8d;
    localparam int          reset_cycles = 2;

    logic        clk;
    logic        rst_n;
    logic [7:0]  in_pins;
    logic [7:0]  out_pins;
    logic        out_strobe;
    logic        halted;
    logic [31:0] rng;
    int          cycles;
    int          limit;
    int          model_steps;
    int          pass_count;
    int          fail_count;
    logic        done;
    logic        timed_out;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    mini_cpu i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_pins    (in_pins),
        .out_pins   (out_pins),
        .out_strobe (out_strobe),
        .halted     (halted)
    );

    cpu_checker #(
        .seed (rng_seed)
    ) i_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_pins    (out_pins),
        .out_strobe  (out_strobe),
        .halted      (halted),
        .model_steps (model_steps),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .done        (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Cycles since reset release
    always @(posedge clk) begin
        if (rst_n === 1'b0) begin
            cycles <= cycles + 1;
        end
    end

    // New input value after every port write
    always @(negedge clk) begin
        if (rst_n === 1'b0 && out_strobe === 1'b1) begin
            rng     = xorshift32(rng);
            in_pins = rng[7:0];
        end
    end

    // ========================================================
    // Main sequence
    // ========================================================
    initial begin
        cycles    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b1;
        rng       = xorshift32(rng_seed);
        in_pins   = rng[7:0];
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b0;
        // Three cycles per instruction plus some slack
        limit = 3 * model_steps + 100;
        while (done !== 1'b1 && cycles < limit) begin
            @(negedge clk);
        end
        if (done !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout: the CPU never halted within %0d cycles", limit);
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
